//--- neo_loader_pkg.sv
`default_nettype none

package neo_loader_pkg;

	// Bus widths
	localparam int IOCTL_AW      = 27;
	localparam int SIZE_W        = 32;
	localparam int P1_AW         = 24;
	localparam int P2_AW         = 26;
	localparam int ADPCMA_AW     = 20;
	localparam int ADPCMA_BANK_W = 4;
	localparam int ADPCMB_AW     = 24;
	localparam int SAMPLE_W      = 32;

	// Cartridge regions in file order
	localparam logic [2:0] REG_P    = 3'd0;
	localparam logic [2:0] REG_S    = 3'd1;
	localparam logic [2:0] REG_M    = 3'd2;
	localparam logic [2:0] REG_V1   = 3'd3;
	localparam logic [2:0] REG_V2   = 3'd4;
	localparam logic [2:0] REG_C    = 3'd5;
	localparam logic [2:0] REG_LAST = 3'd5;

	// Download slots of the host
	localparam logic [7:0] IDX_BIOS          = 8'd0;
	localparam logic [7:0] IDX_CART          = 8'd1;
	localparam logic [7:0] IDX_CART_NO_ADPCM = 8'd2;
	localparam logic [7:0] IDX_SYS_ALT       = 8'd3;

	// NEO file header, sizes live in bytes 4 to 27
	localparam int HDR_SIZE_FIRST = 4;
	localparam int HDR_SIZE_END   = 28;
	localparam int HDR_LEN        = 4096;

	// Bank 3 layout, top bits of the port 1 byte address
	//   0xxx xxxx ...  P ROM
	//   1101 111x ...  LO ROM
	//   1110 0xxx ...  FIX ROM
	//   1110 100x ...  SFIX
	//   1110 11xx ...  SM1
	//   1111 0xxx ...  M ROM
	//   1111 1xxx ...  system ROM
	localparam logic [4:0] PFX_SROM  = 5'b11111;
	localparam logic [7:0] PFX_LOROM = 8'b11011110;
	localparam logic [6:0] PFX_SFIX  = 7'b1110100;
	localparam logic [5:0] PFX_SM1   = 6'b111011;
	localparam logic [4:0] PFX_FIX   = 5'b11100;
	localparam logic [4:0] PFX_MROM  = 5'b11110;

endpackage

`default_nettype wire

//--- neo_header.sv
`timescale 1ns/1ps
`default_nettype none

module neo_header import neo_loader_pkg::*; (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic                ioctl_download,
	input  logic [7:0]          ioctl_index,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	input  logic                ioctl_wr,
	output logic [SIZE_W-1:0]   size_p,
	output logic [SIZE_W-1:0]   size_s,
	output logic [SIZE_W-1:0]   size_m,
	output logic [SIZE_W-1:0]   size_v1,
	output logic [SIZE_W-1:0]   size_v2,
	output logic [SIZE_W-1:0]   size_c,
	output logic [SIZE_W-1:0]   v1_mask,
	output logic [SIZE_W-1:0]   v2_mask,
	output logic                pcm_merged,
	output logic                adpcm_en,
	output logic                hdr_done
);

	logic cart_wr;
	logic in_hdr;
	logic size_byte;
	logic last_byte;

	// Next power of two minus one, zero for sizes of zero or one
	function automatic logic [SIZE_W-1:0] pow2_mask(input logic [SIZE_W-1:0] size);
		logic [SIZE_W-1:0] m;
		m = size - 1'b1;
		m = m | (m >> 1);
		m = m | (m >> 2);
		m = m | (m >> 4);
		m = m | (m >> 8);
		m = m | (m >> 16);
		if (size == '0)
			m = '0;
		return m;
	endfunction

	assign cart_wr   = ioctl_download &&
		(ioctl_index == IDX_CART || ioctl_index == IDX_CART_NO_ADPCM);
	assign in_hdr    = ioctl_addr < HDR_LEN;
	assign size_byte = ioctl_addr >= HDR_SIZE_FIRST && ioctl_addr < HDR_SIZE_END;
	assign last_byte = in_hdr && (&ioctl_addr[11:0]);

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			size_p     <= '0;
			size_s     <= '0;
			size_m     <= '0;
			size_v1    <= '0;
			size_v2    <= '0;
			size_c     <= '0;
			v1_mask    <= '0;
			v2_mask    <= '0;
			pcm_merged <= 1'b0;
			adpcm_en   <= 1'b0;
			hdr_done   <= 1'b0;
		end else begin
			hdr_done <= 1'b0;
			if (cart_wr)
				adpcm_en <= ioctl_index != IDX_CART_NO_ADPCM;
			if (cart_wr && ioctl_wr && size_byte) begin
				// Little-endian words, P first and C last
				{size_c, size_v2, size_v1, size_m, size_s, size_p} <=
					{ioctl_dout, size_c, size_v2, size_v1, size_m, size_s,
					size_p[SIZE_W-1:8]};
			end
			if (cart_wr && ioctl_wr && last_byte) begin
				// No V2 region means ADPCM-A and B share V1
				pcm_merged <= size_v2 == '0;
				v1_mask    <= pow2_mask(size_v1);
				v2_mask    <= pow2_mask(size_v2);
				hdr_done   <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- neo_region_seq.sv
`timescale 1ns/1ps
`default_nettype none

module neo_region_seq import neo_loader_pkg::*; (
	input  logic                CLK_48M,
	input  logic                rst_n,
	input  logic                ioctl_download,
	input  logic [7:0]          ioctl_index,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	input  logic                ioctl_wr,
	input  logic                hdr_done,
	input  logic [SIZE_W-1:0]   size_p,
	input  logic [SIZE_W-1:0]   size_s,
	input  logic [SIZE_W-1:0]   size_m,
	input  logic [SIZE_W-1:0]   size_v1,
	input  logic [SIZE_W-1:0]   size_v2,
	input  logic [SIZE_W-1:0]   size_c,
	input  logic [P1_AW-1:0]    p1_map,
	input  logic [P2_AW-1:0]    p2_map,
	input  logic                p1_ack,
	input  logic                p2_ack,
	output logic [2:0]          region,
	output logic [P2_AW-1:0]    offset,
	output logic                p1_req,
	output logic [P1_AW-1:0]    p1_addr,
	output logic [7:0]          p1_data,
	output logic                p2_req,
	output logic [P2_AW-1:0]    p2_addr,
	output logic [7:0]          p2_data
);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_WAIT  = 2'd1;
	localparam logic [1:0] ST_CHECK = 2'd2;

	logic [1:0]       state;
	logic [P2_AW-1:0] region_size;
	logic             sys_wr;
	logic             cart_wr;
	logic             skip_pcm;
	logic             in_hdr;
	logic             data_wr;
	logic             p1_fire;
	logic             p2_fire;
	logic             port_idle;

	assign sys_wr   = ioctl_download &&
		(ioctl_index == IDX_BIOS || ioctl_index == IDX_SYS_ALT);
	assign cart_wr  = ioctl_download &&
		(ioctl_index == IDX_CART || ioctl_index == IDX_CART_NO_ADPCM);
	assign skip_pcm = ioctl_index == IDX_CART_NO_ADPCM;
	assign in_hdr   = ioctl_addr < HDR_LEN;
	assign data_wr  = ioctl_wr && cart_wr && !in_hdr;

	// P, S and M go to bank 3, the rest to banks 0-2
	assign p1_fire = (ioctl_wr && sys_wr) || (data_wr && region <= REG_M);
	assign p2_fire = data_wr && region >= REG_V1 && region <= REG_LAST &&
		!(skip_pcm && region <= REG_V2);

	assign port_idle = (region <= REG_M) ? (p1_req == p1_ack) : (p2_req == p2_ack);

	always_comb begin
		case (region)
			REG_P:   region_size = size_p[P2_AW-1:0];
			REG_S:   region_size = size_s[P2_AW-1:0];
			REG_M:   region_size = size_m[P2_AW-1:0];
			REG_V1:  region_size = size_v1[P2_AW-1:0];
			REG_V2:  region_size = size_v2[P2_AW-1:0];
			REG_C:   region_size = size_c[P2_AW-1:0];
			default: region_size = '0;
		endcase
	end

	always_ff @(posedge CLK_48M) begin
		if (p1_fire) begin
			p1_addr <= p1_map;
			p1_data <= ioctl_dout;
		end
		if (p2_fire) begin
			p2_addr <= p2_map;
			p2_data <= ioctl_dout;
		end
	end

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			state  <= ST_IDLE;
			region <= REG_P;
			offset <= '0;
			p1_req <= 1'b0;
			p2_req <= 1'b0;
		end else begin
			if (p1_fire)
				p1_req <= ~p1_req;
			if (p2_fire)
				p2_req <= ~p2_req;
			if (ioctl_wr && cart_wr && in_hdr) begin
				region <= REG_P;
				offset <= '0;
			end
			case (state)
				ST_IDLE: begin
					// After the header the first regions may be empty
					if (hdr_done)
						state <= ST_CHECK;
					else if (data_wr)
						state <= ST_WAIT;
				end
				ST_WAIT: begin
					if (port_idle) begin
						offset <= offset + 1'b1;
						state  <= ST_CHECK;
					end
				end
				ST_CHECK: begin
					if (offset == region_size) begin
						offset <= '0;
						region <= region + 1'b1;
						if (region == REG_LAST)
							state <= ST_IDLE;
					end else begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- neo_addr_map.sv
`timescale 1ns/1ps
`default_nettype none

module neo_addr_map import neo_loader_pkg::*; (
	input  logic [7:0]          ioctl_index,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [2:0]          region,
	input  logic [P2_AW-1:0]    offset,
	input  logic [SIZE_W-1:0]   size_c,
	input  logic [SIZE_W-1:0]   size_v1,
	output logic [P1_AW-1:0]    p1_map,
	output logic [P2_AW-1:0]    p2_map
);

	logic             sys_idx;
	logic [P1_AW-1:0] sys_map;
	logic [P1_AW-1:0] cart_map;

	assign sys_idx = ioctl_index == IDX_BIOS || ioctl_index == IDX_SYS_ALT;

	// System ROM set, windowed by the download address
	always_comb begin
		if (ioctl_addr[23:19] == 5'd0)
			sys_map = {PFX_SROM, ioctl_addr[18:0]};
		else if (ioctl_addr[23:17] == 7'h04)
			sys_map = {PFX_LOROM, ioctl_addr[15:0]};
		else if (ioctl_addr[23:17] == 7'h05)
			// FIX tiles are stored column interleaved
			sys_map = {PFX_SFIX, ioctl_addr[16:5], ioctl_addr[2:0],
				~ioctl_addr[4], ioctl_addr[3]};
		else
			sys_map = {PFX_SM1, ioctl_addr[17:0]};
	end

	always_comb begin
		case (region)
			REG_S:   cart_map = {PFX_FIX, offset[18:5], offset[2:0], ~offset[4], offset[3]};
			REG_M:   cart_map = {PFX_MROM, offset[18:0]};
			default: cart_map = offset[P1_AW-1:0];
		endcase
	end

	assign p1_map = sys_idx ? sys_map : cart_map;

	// Banks 0-2 hold C, then V1, then V2
	always_comb begin
		case (region)
			REG_V1:  p2_map = P2_AW'(size_c + offset);
			REG_V2:  p2_map = P2_AW'(size_c + size_v1 + offset);
			default: p2_map = {offset[25:7], ioctl_addr[5:2], ~ioctl_addr[6],
				ioctl_addr[0], ioctl_addr[1]};
		endcase
	end

endmodule

`default_nettype wire

//--- adpcm_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module adpcm_fetch import neo_loader_pkg::*; #(
	parameter logic [7:0] SILENCE = 8'h80
) (
	input  logic                 CLK_48M,
	input  logic                 rst_n,
	input  logic                 rd,
	input  logic [ADPCMB_AW-1:0] addr,
	input  logic [ADPCMB_AW-1:0] mask,
	input  logic [P2_AW-1:0]     base,
	input  logic                 adpcm_en,
	input  logic                 ack,
	input  logic [SAMPLE_W-1:0]  q,
	output logic                 req,
	output logic [P2_AW-1:0]     sample_addr,
	output logic [7:0]           data,
	output logic                 ready
);

	logic                 rd_d;
	logic                 rd_rise;
	logic [ADPCMB_AW-1:0] masked;
	logic [ADPCMB_AW-1:0] latch;

	assign rd_rise = rd && !rd_d;
	assign masked  = addr & mask;

	always_ff @(posedge CLK_48M or negedge rst_n) begin
		if (!rst_n) begin
			rd_d  <= 1'b0;
			req   <= 1'b0;
			latch <= '0;
		end else begin
			rd_d <= rd;
			if (rd_rise && adpcm_en) begin
				// The 32-bit word already fetched serves all four bytes
				if (masked[ADPCMB_AW-1:2] != latch[ADPCMB_AW-1:2])
					req <= ~req;
				latch <= masked;
			end
		end
	end

	assign sample_addr = P2_AW'(base + latch);
	assign ready       = req == ack;

	always_comb begin
		if (!adpcm_en)
			data = SILENCE;
		else
			data = q[latch[1:0]*8 +: 8];
	end

endmodule

`default_nettype wire

//--- neo_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module neo_loader_top import neo_loader_pkg::*; #(
	parameter logic [7:0] SILENCE = 8'h80
) (
	input  logic                     CLK_48M,
	input  logic                     rst_n,
	input  logic                     ioctl_download,
	input  logic [7:0]               ioctl_index,
	input  logic [IOCTL_AW-1:0]      ioctl_addr,
	input  logic [7:0]               ioctl_dout,
	input  logic                     ioctl_wr,
	output logic                     p1_req,
	output logic [P1_AW-1:0]         p1_addr,
	output logic [7:0]               p1_data,
	input  logic                     p1_ack,
	output logic                     p2_req,
	output logic [P2_AW-1:0]         p2_addr,
	output logic [7:0]               p2_data,
	input  logic                     p2_ack,
	output logic                     sa_req,
	output logic [P2_AW-1:0]         sa_addr,
	input  logic                     sa_ack,
	input  logic [SAMPLE_W-1:0]      sa_q,
	output logic                     sb_req,
	output logic [P2_AW-1:0]         sb_addr,
	input  logic                     sb_ack,
	input  logic [SAMPLE_W-1:0]      sb_q,
	input  logic [ADPCMA_AW-1:0]     adpcma_addr,
	input  logic [ADPCMA_BANK_W-1:0] adpcma_bank,
	input  logic                     adpcma_rd,
	input  logic [ADPCMB_AW-1:0]     adpcmb_addr,
	input  logic                     adpcmb_rd,
	output logic [7:0]               adpcma_data,
	output logic                     adpcma_ready,
	output logic [7:0]               adpcmb_data,
	output logic                     adpcmb_ready
);

	logic [SIZE_W-1:0]    size_p;
	logic [SIZE_W-1:0]    size_s;
	logic [SIZE_W-1:0]    size_m;
	logic [SIZE_W-1:0]    size_v1;
	logic [SIZE_W-1:0]    size_v2;
	logic [SIZE_W-1:0]    size_c;
	logic [SIZE_W-1:0]    v1_mask;
	logic [SIZE_W-1:0]    v2_mask;
	logic                 pcm_merged;
	logic                 adpcm_en;
	logic                 hdr_done;
	logic [2:0]           region;
	logic [P2_AW-1:0]     offset;
	logic [P1_AW-1:0]     p1_map;
	logic [P2_AW-1:0]     p2_map;
	logic [ADPCMB_AW-1:0] sb_mask;
	logic [P2_AW-1:0]     sb_base;

	neo_header u_header (
		.CLK_48M        (CLK_48M),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.size_p         (size_p),
		.size_s         (size_s),
		.size_m         (size_m),
		.size_v1        (size_v1),
		.size_v2        (size_v2),
		.size_c         (size_c),
		.v1_mask        (v1_mask),
		.v2_mask        (v2_mask),
		.pcm_merged     (pcm_merged),
		.adpcm_en       (adpcm_en),
		.hdr_done       (hdr_done)
	);

	neo_region_seq u_seq (
		.CLK_48M        (CLK_48M),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.hdr_done       (hdr_done),
		.size_p         (size_p),
		.size_s         (size_s),
		.size_m         (size_m),
		.size_v1        (size_v1),
		.size_v2        (size_v2),
		.size_c         (size_c),
		.p1_map         (p1_map),
		.p2_map         (p2_map),
		.p1_ack         (p1_ack),
		.p2_ack         (p2_ack),
		.region         (region),
		.offset         (offset),
		.p1_req         (p1_req),
		.p1_addr        (p1_addr),
		.p1_data        (p1_data),
		.p2_req         (p2_req),
		.p2_addr        (p2_addr),
		.p2_data        (p2_data)
	);

	neo_addr_map u_map (
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.region      (region),
		.offset      (offset),
		.size_c      (size_c),
		.size_v1     (size_v1),
		.p1_map      (p1_map),
		.p2_map      (p2_map)
	);

	// Merged carts keep ADPCM-B inside V1
	assign sb_mask = pcm_merged ? v1_mask[ADPCMB_AW-1:0] : v2_mask[ADPCMB_AW-1:0];
	assign sb_base = P2_AW'(size_c + ({SIZE_W{~pcm_merged}} & size_v1));

	adpcm_fetch #(
		.SILENCE (SILENCE)
	) u_fetch_a (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.rd          (adpcma_rd),
		.addr        ({adpcma_bank, adpcma_addr}),
		.mask        (v1_mask[ADPCMB_AW-1:0]),
		.base        (size_c[P2_AW-1:0]),
		.adpcm_en    (adpcm_en),
		.ack         (sa_ack),
		.q           (sa_q),
		.req         (sa_req),
		.sample_addr (sa_addr),
		.data        (adpcma_data),
		.ready       (adpcma_ready)
	);

	adpcm_fetch #(
		.SILENCE (SILENCE)
	) u_fetch_b (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.rd          (adpcmb_rd),
		.addr        (adpcmb_addr),
		.mask        (sb_mask),
		.base        (sb_base),
		.adpcm_en    (adpcm_en),
		.ack         (sb_ack),
		.q           (sb_q),
		.req         (sb_req),
		.sample_addr (sb_addr),
		.data        (adpcmb_data),
		.ready       (adpcmb_ready)
	);

endmodule

`default_nettype wire

//--- tb_neo_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_neo_loader import neo_loader_pkg::*; ();

	localparam int N_BIOS    = 48;
	localparam int N_CARTS   = 4;
	localparam int HDR_BYTES = 25;
	localparam int MAX_SIZE  = 16;
	localparam int N_READS   = 12;
	// Bytes sent plus read strobes at up to 20 cycles each
	localparam int XFERS     = N_BIOS + N_CARTS * (HDR_BYTES + 6 * MAX_SIZE + 2 * N_READS);
	localparam int WATCHDOG_CYCLES = XFERS * 20 + 1000;

	logic                     CLK_48M = 1'b0;
	logic                     rst_n;
	logic                     ioctl_download;
	logic [7:0]               ioctl_index;
	logic [IOCTL_AW-1:0]      ioctl_addr;
	logic [7:0]               ioctl_dout;
	logic                     ioctl_wr;
	logic                     p1_req;
	logic [P1_AW-1:0]         p1_addr;
	logic [7:0]               p1_data;
	logic                     p1_ack = 1'b0;
	logic                     p2_req;
	logic [P2_AW-1:0]         p2_addr;
	logic [7:0]               p2_data;
	logic                     p2_ack = 1'b0;
	logic                     sa_req;
	logic [P2_AW-1:0]         sa_addr;
	logic                     sa_ack = 1'b0;
	logic [SAMPLE_W-1:0]      sa_q = '0;
	logic                     sb_req;
	logic [P2_AW-1:0]         sb_addr;
	logic                     sb_ack = 1'b0;
	logic [SAMPLE_W-1:0]      sb_q = '0;
	logic [ADPCMA_AW-1:0]     adpcma_addr;
	logic [ADPCMA_BANK_W-1:0] adpcma_bank;
	logic                     adpcma_rd;
	logic [ADPCMB_AW-1:0]     adpcmb_addr;
	logic                     adpcmb_rd;
	logic [7:0]               adpcma_data;
	logic                     adpcma_ready;
	logic [7:0]               adpcmb_data;
	logic                     adpcmb_ready;

	int                   exp_port[$];
	logic [P2_AW-1:0]     exp_addr[$];
	logic [7:0]           exp_data[$];
	logic [31:0]          stim_rng = 32'd27;
	logic [31:0]          mdl_rng = 32'd27;
	int                   p1_wait;
	int                   p2_wait;
	int                   sa_wait;
	int                   sb_wait;
	bit                   p1_busy;
	bit                   p2_busy;
	bit                   sa_busy;
	bit                   sb_busy;
	logic [ADPCMB_AW-1:0] last_lat [2];
	bit                   word_ok [2];

	neo_loader_top #(.SILENCE(8'h80)) UUT (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		stim_rng = xorshift(stim_rng);
		return stim_rng;
	endfunction

	// Sample memory holds a hash of the byte address
	function automatic logic [7:0] byte_at(input logic [P2_AW-1:0] a);
		logic [P2_AW-1:0] h;
		h = a * 26'd37 + (a >> 9);
		return h[7:0] ^ 8'h5a;
	endfunction

	function automatic logic [SAMPLE_W-1:0] word_at(input logic [P2_AW-1:0] a);
		logic [P2_AW-1:0] w;
		w = {a[P2_AW-1:2], 2'b00};
		return {byte_at(w + 26'd3), byte_at(w + 26'd2), byte_at(w + 26'd1), byte_at(w)};
	endfunction

	function automatic logic [SIZE_W-1:0] mask_for(input logic [SIZE_W-1:0] size);
		logic [SIZE_W-1:0] m;
		m = '0;
		while (m + 1 < size)
			m = {m[SIZE_W-2:0], 1'b1};
		return m;
	endfunction

	task automatic fail_now();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("** Error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		fail_now();
	endtask

	task automatic check_write(input int port, input logic [P2_AW-1:0] addr,
		input logic [7:0] data);
		int               ep;
		logic [P2_AW-1:0] ea;
		logic [7:0]       ed;
		if (exp_port.size() == 0) begin
			$display("Unexpected write on port %0d at %0t ns", port, $time);
			fail_now();
		end else begin
			ep = exp_port.pop_front();
			ea = exp_addr.pop_front();
			ed = exp_data.pop_front();
			if (port != ep)
				report_value("write port", 32'(port), 32'(ep));
			else if (addr !== ea)
				report_value(port == 1 ? "p1_addr" : "p2_addr", 32'(addr), 32'(ea));
			else if (data !== ed)
				report_value(port == 1 ? "p1_data" : "p2_data", 32'(data), 32'(ed));
		end
	endtask

	task automatic check_sample(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp)
			report_value(name, 32'(got), 32'(exp));
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_value(name, 32'(got), 32'(exp));
	endtask

	task automatic expect_write(input int port, input logic [P2_AW-1:0] addr,
		input logic [7:0] data);
		exp_port.push_back(port);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic check_drained();
		if (exp_port.size() != 0) begin
			$display("%0d expected writes never arrived", exp_port.size());
			fail_now();
		end
	endtask

	task automatic tick(input int n);
		repeat (n) @(negedge CLK_48M);
	endtask

	task automatic apply_reset();
		@(negedge CLK_48M);
		rst_n = 1'b0;
		tick(2);
		rst_n = 1'b1;
		last_lat[0] = '0;
		last_lat[1] = '0;
		word_ok[0] = 1'b0;
		word_ok[1] = 1'b0;
	endtask

	task automatic send_byte(input logic [7:0] idx, input logic [IOCTL_AW-1:0] a,
		input logic [7:0] d);
		@(negedge CLK_48M);
		ioctl_index = idx;
		ioctl_addr = a;
		ioctl_dout = d;
		ioctl_wr = 1'b1;
		@(negedge CLK_48M);
		ioctl_wr = 1'b0;
		do begin
			@(posedge CLK_48M);
			#1;
		end while (p1_req != p1_ack || p2_req != p2_ack);
		// Room for the region skip after a region ends
		tick(8);
	endtask

	task automatic read_sample(input int ch, input logic [ADPCMB_AW-1:0] a,
		input logic [ADPCMB_AW-1:0] m, input logic [P2_AW-1:0] base, input bit en);
		logic [ADPCMB_AW-1:0] masked;
		logic                 fetch;
		string                tag;
		masked = a & m;
		fetch = en && masked[ADPCMB_AW-1:2] != last_lat[ch][ADPCMB_AW-1:2];
		tag = (ch == 0) ? "a" : "b";
		@(negedge CLK_48M);
		if (ch == 0) begin
			{adpcma_bank, adpcma_addr} = a;
			adpcma_rd = 1'b1;
		end else begin
			adpcmb_addr = a;
			adpcmb_rd = 1'b1;
		end
		@(posedge CLK_48M);
		#1;
		check_ready({"adpcm", tag, "_ready"}, ch == 0 ? adpcma_ready : adpcmb_ready, !fetch);
		@(negedge CLK_48M);
		adpcma_rd = 1'b0;
		adpcmb_rd = 1'b0;
		do begin
			@(posedge CLK_48M);
			#1;
		end while (!(ch == 0 ? adpcma_ready : adpcmb_ready));
		// The word held after reset was never fetched
		if (!en || fetch || word_ok[ch])
			check_sample({"adpcm", tag, "_data"}, ch == 0 ? adpcma_data : adpcmb_data,
				en ? byte_at(P2_AW'(base + P2_AW'(masked))) : 8'h80);
		if (en) begin
			last_lat[ch] = masked;
			word_ok[ch] = word_ok[ch] | fetch;
		end
	endtask

	initial begin
		forever #5 CLK_48M = ~CLK_48M;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK_48M);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	// SDRAM model with one random delay per toggle
	always @(negedge CLK_48M) begin
		if (!rst_n) begin
			p1_ack = 1'b0;
			p2_ack = 1'b0;
			sa_ack = 1'b0;
			sb_ack = 1'b0;
			p1_busy = 1'b0;
			p2_busy = 1'b0;
			sa_busy = 1'b0;
			sb_busy = 1'b0;
		end else begin
			if (p1_busy) begin
				if (p1_wait == 0) begin
					p1_ack = ~p1_ack;
					p1_busy = 1'b0;
				end else
					p1_wait--;
			end else if (p1_req != p1_ack) begin
				check_write(1, P2_AW'(p1_addr), p1_data);
				mdl_rng = xorshift(mdl_rng);
				p1_wait = int'(mdl_rng[2:0]);
				p1_busy = 1'b1;
			end
			if (p2_busy) begin
				if (p2_wait == 0) begin
					p2_ack = ~p2_ack;
					p2_busy = 1'b0;
				end else
					p2_wait--;
			end else if (p2_req != p2_ack) begin
				check_write(2, p2_addr, p2_data);
				mdl_rng = xorshift(mdl_rng);
				p2_wait = int'(mdl_rng[2:0]);
				p2_busy = 1'b1;
			end
			if (sa_busy) begin
				if (sa_wait == 0) begin
					sa_ack = ~sa_ack;
					sa_busy = 1'b0;
				end else
					sa_wait--;
			end else if (sa_req != sa_ack) begin
				sa_q = word_at(sa_addr);
				mdl_rng = xorshift(mdl_rng);
				sa_wait = int'(mdl_rng[2:0]);
				sa_busy = 1'b1;
			end
			if (sb_busy) begin
				if (sb_wait == 0) begin
					sb_ack = ~sb_ack;
					sb_busy = 1'b0;
				end else
					sb_wait--;
			end else if (sb_req != sb_ack) begin
				sb_q = word_at(sb_addr);
				mdl_rng = xorshift(mdl_rng);
				sb_wait = int'(mdl_rng[2:0]);
				sb_busy = 1'b1;
			end
		end
	end

	initial begin
		logic [31:0]         r;
		logic [IOCTL_AW-1:0] a;
		logic [P1_AW-1:0]    exp24;
		logic [7:0]          d;
		logic [7:0]          idx;
		logic [SIZE_W-1:0]   sz [6];
		logic [P2_AW-1:0]    off;
		logic [SIZE_W-1:0]   mask_a;
		logic [SIZE_W-1:0]   mask_b;
		logic [P2_AW-1:0]    base_a;
		logic [P2_AW-1:0]    base_b;
		bit                  merged;
		bit                  en;
		int                  n;
		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		adpcma_addr = '0;
		adpcma_bank = '0;
		adpcma_rd = 1'b0;
		adpcmb_addr = '0;
		adpcmb_rd = 1'b0;
		apply_reset();

		// System ROM set across the four address windows
		ioctl_download = 1'b1;
		for (int i = 0; i < N_BIOS; i++) begin
			r = next_rand();
			case (r[25:24])
				2'd0: begin
					a = {8'h00, r[18:0]};
					exp24 = {PFX_SROM, r[18:0]};
				end
				2'd1: begin
					a = {3'b000, 7'h04, r[16:0]};
					exp24 = {PFX_LOROM, r[15:0]};
				end
				2'd2: begin
					a = {3'b000, 7'h05, r[16:0]};
					exp24 = {PFX_SFIX, r[16:5], r[2:0], ~r[4], r[3]};
				end
				default: begin
					a = {3'b000, 6'b000011, r[17:0]};
					exp24 = {PFX_SM1, r[17:0]};
				end
			endcase
			idx = r[31] ? IDX_SYS_ALT : IDX_BIOS;
			d = r[7:0] ^ r[15:8];
			expect_write(1, P2_AW'(exp24), d);
			send_byte(idx, a, d);
		end
		ioctl_download = 1'b0;
		tick(10);
		check_drained();

		for (int c = 0; c < N_CARTS; c++) begin
			idx = (c == N_CARTS - 1) ? IDX_CART_NO_ADPCM : IDX_CART;
			for (int k = 0; k < 6; k++) begin
				r = next_rand();
				sz[k] = SIZE_W'(4 * (r % 5));
			end
			if (c == 0)
				sz[REG_V2] = '0;
			if (c == 1 && sz[REG_V2] < 32'd8)
				sz[REG_V2] = 32'd8;
			// Sample masks wide enough that reads cross words
			if (sz[REG_V1] < 32'd8)
				sz[REG_V1] = 32'd8;
			apply_reset();
			ioctl_download = 1'b1;
			for (int b = 0; b < 24; b++)
				send_byte(idx, IOCTL_AW'(HDR_SIZE_FIRST + b), sz[b / 4][8 * (b % 4) +: 8]);
			r = next_rand();
			send_byte(idx, IOCTL_AW'(HDR_LEN - 1), r[7:0]);
			n = 0;
			for (int k = 0; k < 6; k++) begin
				for (int o = 0; o < int'(sz[k]); o++) begin
					a = IOCTL_AW'(HDR_LEN + n);
					off = P2_AW'(o);
					r = next_rand();
					d = r[7:0];
					case (k)
						0: expect_write(1, P2_AW'(off[P1_AW-1:0]), d);
						1: expect_write(1, P2_AW'({PFX_FIX, off[18:5], off[2:0], ~off[4], off[3]}), d);
						2: expect_write(1, P2_AW'({PFX_MROM, off[18:0]}), d);
						3: if (idx == IDX_CART)
							expect_write(2, sz[5][P2_AW-1:0] + off, d);
						4: if (idx == IDX_CART)
							expect_write(2, sz[5][P2_AW-1:0] + sz[3][P2_AW-1:0] + off, d);
						default: expect_write(2, {off[25:7], a[5:2], ~a[6], a[0], a[1]}, d);
					endcase
					send_byte(idx, a, d);
					n++;
				end
			end
			ioctl_download = 1'b0;
			tick(10);
			check_drained();

			merged = sz[REG_V2] == '0;
			en = idx == IDX_CART;
			mask_a = mask_for(sz[REG_V1]);
			mask_b = merged ? mask_for(sz[REG_V1]) : mask_for(sz[REG_V2]);
			base_a = sz[REG_C][P2_AW-1:0];
			base_b = merged ? base_a : base_a + sz[REG_V1][P2_AW-1:0];
			for (int i = 0; i < N_READS; i++) begin
				r = next_rand();
				read_sample(0, r[23:0], mask_a[ADPCMB_AW-1:0], base_a, en);
				r = next_rand();
				read_sample(1, r[23:0], mask_b[ADPCMB_AW-1:0], base_b, en);
			end
		end

		tick(5);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- neo_loader.f
neo_loader_pkg.sv
neo_header.sv
neo_region_seq.sv
neo_addr_map.sv
adpcm_fetch.sv
neo_loader_top.sv
tb_neo_loader.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_neo_loader
FILELIST  ?= neo_loader.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
